// File: all.f
verilog/softmax_num_pkg.sv
verilog/softmax_seq_pkg.sv
verilog/row_if.sv
verilog/row_buffer.sv
verilog/max_tree.sv
verilog/exp_stage.sv
verilog/adder_tree.sv
verilog/row_sequencer.sv
verilog/softmax_top.sv
bench/softmax_tb.sv

// File: Makefile
TOP = softmax_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f -Mdir build
	./build/V$(TOP) | tee build/sim.log
	grep -q "all tests passed" build/sim.log

clean:
	rm -rf build

// File: bench/softmax_tb.sv
`timescale 1ns/1ps

module softmax_tb;
  import softmax_num_pkg::*;

  localparam int addr_w = 3;
  localparam int depth = 2**addr_w;
  localparam int case_count = 6;
  localparam int timeout_cycles = case_count * (3 * depth + 20);

  // start, end, lane spread, negative-only flag
  // case 2 is the widest block allowed, case 3 follows it with negatives only
  int case_start [case_count] = '{0, 2, 0, 1, 5, 3};
  int case_end [case_count] = '{4, 7, 7, 6, 6, 7};
  int case_spread [case_count] = '{12, 40, 30000, 10, 20, 8};
  bit case_neg [case_count] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

  logic              clk = 1'b0;
  logic              reset;
  logic              init;
  logic              start;
  logic [addr_w-1:0] start_addr;
  logic [addr_w-1:0] end_addr;
  row_t              inp = '0;
  logic [addr_w-1:0] addr;
  term_t             term0;
  term_t             term1;
  term_t             term2;
  term_t             term3;
  logic              term_valid;
  lane_t             max_value;
  sum_t              sum;
  logic              done;

  row_t mem [depth];
  int   exp_terms [$];
  int   got_terms [$];
  int   exp_max;
  int   exp_sum;
  int   done_count = 0;
  int   cycle_count = 0;
  int   mismatch_count = 0;
  int   other_count = 0;

  softmax_top #(
    .addr_w (addr_w)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .inp        (inp),
    .addr       (addr),
    .term0      (term0),
    .term1      (term1),
    .term2      (term2),
    .term3      (term3),
    .term_valid (term_valid),
    .max_value  (max_value),
    .sum        (sum),
    .done       (done)
  );

  always #20 clk = ~clk;

  // row memory, data one cycle after the address
  always @(posedge clk) begin
    inp <= mem[addr];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: no done pulse within %0d cycles", timeout_cycles);
      $display("tests failed");
      $finish;
    end
  end

  // collect term rows and done pulses away from the active edge
  always @(negedge clk) begin
    if (!reset) begin
      if (term_valid) begin
        got_terms.push_back(int'(term0));
        got_terms.push_back(int'(term1));
        got_terms.push_back(int'(term2));
        got_terms.push_back(int'(term3));
      end
      if (done) begin
        done_count = done_count + 1;
      end
    end
  end

  task automatic fill_memory(input int spread, input bit neg_only);
    int v;
    for (int a = 0; a < depth; a++) begin
      for (int l = 0; l < lane_count; l++) begin
        v = int'($urandom % unsigned'(spread));
        if (neg_only) begin
          v = -1 - v;
        end
        mem[a][l] = lane_t'(v);
      end
    end
  endtask

  // base-2 term: 2^0 is 32768, halved per step of difference
  function automatic int term_of(input int diff);
    if (diff >= 16) begin
      return 0;
    end
    return 32768 >> diff;
  endfunction

  task automatic build_expected(input int first_a, input int end_a);
    int t;
    exp_max = int'(mem[first_a][0]);
    for (int a = first_a; a < end_a; a++) begin
      for (int l = 0; l < lane_count; l++) begin
        if (int'(mem[a][l]) > exp_max) begin
          exp_max = int'(mem[a][l]);
        end
      end
    end
    exp_terms.delete();
    exp_sum = 0;
    for (int a = first_a; a < end_a; a++) begin
      for (int l = 0; l < lane_count; l++) begin
        t = term_of(exp_max - int'(mem[a][l]));
        exp_terms.push_back(t);
        exp_sum = exp_sum + t;
      end
    end
  endtask

  task automatic run_case(input int idx);
    int got_max;
    int got_sum;
    int rows;
    fill_memory(case_spread[idx], case_neg[idx]);
    build_expected(case_start[idx], case_end[idx]);
    rows = case_end[idx] - case_start[idx];
    got_terms.delete();
    done_count = 0;
    @(posedge clk);
    init <= 1'b1;
    start_addr <= addr_w'(case_start[idx]);
    end_addr <= addr_w'(case_end[idx]);
    @(posedge clk);
    init <= 1'b0;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(negedge clk);
    end while (!done);
    got_max = int'(max_value);
    got_sum = int'(sum);
    // watch for a second done before checking
    repeat (4) @(posedge clk);

    assert (got_max == exp_max) else begin
      mismatch_count++;
      $display("Mismatch at %0t: case %0d max_value %0d, expected %0d",
               $time, idx, got_max, exp_max);
    end
    assert (got_sum == exp_sum) else begin
      mismatch_count++;
      $display("Mismatch at %0t: case %0d sum %0d, expected %0d",
               $time, idx, got_sum, exp_sum);
    end
    assert (done_count == 1) else begin
      other_count++;
      $display("case %0d: done pulsed %0d times for one start", idx, done_count);
    end
    assert (got_terms.size() == rows * lane_count) else begin
      other_count++;
      $display("case %0d: got %0d term rows, expected %0d",
               idx, got_terms.size() / lane_count, rows);
    end
    for (int i = 0; i < got_terms.size() && i < exp_terms.size(); i++) begin
      assert (got_terms[i] == exp_terms[i]) else begin
        mismatch_count++;
        $display("Mismatch at %0t: case %0d row %0d lane %0d term %0d, expected %0d",
                 $time, idx, i / lane_count, i % lane_count, got_terms[i], exp_terms[i]);
      end
    end
  endtask

  initial begin
    int seed_value;
    seed_value = $urandom(42);
    reset = 1'b1;
    init = 1'b0;
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    // outputs straight after reset
    assert (!term_valid && !done) else begin
      mismatch_count++;
      $display("Mismatch at %0t: term_valid %0b done %0b after reset, expected 0",
               $time, term_valid, done);
    end
    assert (sum == '0 && max_value == '0) else begin
      mismatch_count++;
      $display("Mismatch at %0t: sum %0d max_value %0d after reset, expected 0",
               $time, sum, max_value);
    end

    for (int i = 0; i < case_count; i++) begin
      run_case(i);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/softmax_top.sv
`timescale 1ns/1ps

module softmax_top #(
  parameter int addr_w = 3
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   init,
  input  logic                   start,
  input  logic [addr_w-1:0]      start_addr,
  input  logic [addr_w-1:0]      end_addr,
  input  softmax_num_pkg::row_t  inp,
  output logic [addr_w-1:0]      addr,
  output softmax_num_pkg::term_t term0,
  output softmax_num_pkg::term_t term1,
  output softmax_num_pkg::term_t term2,
  output softmax_num_pkg::term_t term3,
  output logic                   term_valid,
  output softmax_num_pkg::lane_t max_value,
  output softmax_num_pkg::sum_t  sum,
  output logic                   done
);
  import softmax_num_pkg::*;

  row_if load_rows ();
  row_if scan_rows ();
  row_if term_rows ();

  logic              max_ready;
  logic              busy;
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  row_t              wr_row;
  row_t              rd_row;
  term_row_t         term_row;

  row_sequencer #(
    .addr_w (addr_w)
  ) u_row_sequencer (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .inp        (inp),
    .addr       (addr),
    .max_ready  (max_ready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .rd_addr    (rd_addr),
    .wr_row     (wr_row),
    .rd_row     (rd_row),
    .load_rows  (load_rows),
    .scan_rows  (scan_rows),
    .busy       (busy)
  );

  row_buffer #(
    .addr_w (addr_w)
  ) u_row_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_row  (wr_row),
    .rd_row  (rd_row)
  );

  max_tree u_max_tree (
    .clk       (clk),
    .reset     (reset),
    .rows      (load_rows),
    .max_value (max_value),
    .max_ready (max_ready)
  );

  exp_stage u_exp_stage (
    .clk       (clk),
    .reset     (reset),
    .max_value (max_value),
    .rows      (scan_rows),
    .terms     (term_rows)
  );

  adder_tree u_adder_tree (
    .clk   (clk),
    .reset (reset),
    .terms (term_rows),
    .busy  (busy),
    .sum   (sum),
    .done  (done)
  );

  // term rows share the 64-bit row field
  assign term_row = term_rows.row;
  assign term0 = term_row[0];
  assign term1 = term_row[1];
  assign term2 = term_row[2];
  assign term3 = term_row[3];
  assign term_valid = term_rows.valid;

endmodule

// File: verilog/row_sequencer.sv
`timescale 1ns/1ps

module row_sequencer #(
  parameter int addr_w = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  init,
  input  logic                  start,
  input  logic [addr_w-1:0]     start_addr,
  input  logic [addr_w-1:0]     end_addr,
  input  softmax_num_pkg::row_t inp,
  output logic [addr_w-1:0]     addr,
  input  logic                  max_ready,
  output logic                  wr_en,
  output logic [addr_w-1:0]     wr_addr,
  output logic [addr_w-1:0]     rd_addr,
  output softmax_num_pkg::row_t wr_row,
  input  softmax_num_pkg::row_t rd_row,
  row_if.source                 load_rows,
  row_if.source                 scan_rows,
  output logic                  busy
);
  import softmax_seq_pkg::*;

  // exp stage plus three adder stages
  localparam int drain_cycles = 4;

  if (addr_w < 2 || addr_w > max_addr_w) begin : g_addr_w_check
    $error("row_sequencer: addr_w out of range");
  end

  phase_t            phase;
  logic [addr_w-1:0] base_addr;
  logic [addr_w-1:0] stop_addr;
  logic [1:0]        drain_cnt;
  logic              load_end;
  logic              scan_end;
  logic              load_valid;
  logic              load_first;
  logic              load_last;
  logic              scan_valid;
  logic              scan_first;
  logic              scan_last;

  assign load_end = (addr == stop_addr - 1'b1);
  assign scan_end = (rd_addr == stop_addr - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= idle;
      addr <= '0;
      base_addr <= '0;
      stop_addr <= '0;
      rd_addr <= '0;
      drain_cnt <= '0;
    end else begin
      case (phase)
        idle: begin
          if (init) begin
            addr <= start_addr;
          end
          if (start) begin
            base_addr <= addr;
            stop_addr <= end_addr;
            phase <= load;
          end
        end
        load: begin
          addr <= addr + 1'b1;
          if (load_end) begin
            rd_addr <= base_addr;
            phase <= max_wait;
          end
        end
        max_wait: begin
          if (max_ready) begin
            phase <= scan;
          end
        end
        scan: begin
          rd_addr <= rd_addr + 1'b1;
          if (scan_end) begin
            drain_cnt <= '0;
            phase <= drain;
          end
        end
        drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'(drain_cycles - 1)) begin
            phase <= idle;
          end
        end
        default: phase <= idle;
      endcase
    end
  end

  // markers follow the one-cycle memory and buffer reads
  always_ff @(posedge clk) begin
    if (reset) begin
      load_valid <= 1'b0;
      load_first <= 1'b0;
      load_last <= 1'b0;
      scan_valid <= 1'b0;
      scan_first <= 1'b0;
      scan_last <= 1'b0;
    end else begin
      load_valid <= (phase == load);
      load_first <= (phase == load) && (addr == base_addr);
      load_last <= (phase == load) && load_end;
      scan_valid <= (phase == scan);
      scan_first <= (phase == scan) && (rd_addr == base_addr);
      scan_last <= (phase == scan) && scan_end;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= addr;
  end

  assign wr_en = load_valid;
  assign wr_row = inp;

  assign load_rows.row = inp;
  assign load_rows.valid = load_valid;
  assign load_rows.first = load_first;
  assign load_rows.last = load_last;

  assign scan_rows.row = rd_row;
  assign scan_rows.valid = scan_valid;
  assign scan_rows.first = scan_first;
  assign scan_rows.last = scan_last;

  assign busy = (phase != idle);

endmodule

// File: verilog/adder_tree.sv
`timescale 1ns/1ps

module adder_tree (
  input  logic                  clk,
  input  logic                  reset,
  row_if.sink                   terms,
  input  logic                  busy,
  output softmax_num_pkg::sum_t sum,
  output logic                  done
);
  import softmax_num_pkg::*;

  term_row_t         term_row;
  logic [term_w:0]   pair0;
  logic [term_w:0]   pair1;
  logic [term_w+1:0] total;
  logic              pair_valid;
  logic              pair_last;
  logic              total_valid;
  logic              total_last;
  logic              busy_d;

  assign term_row = terms.row;

  // pair sums, then the row total
  always_ff @(posedge clk) begin
    pair0 <= {1'b0, term_row[0]} + {1'b0, term_row[1]};
    pair1 <= {1'b0, term_row[2]} + {1'b0, term_row[3]};
    total <= {1'b0, pair0} + {1'b0, pair1};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_valid <= 1'b0;
      pair_last <= 1'b0;
      total_valid <= 1'b0;
      total_last <= 1'b0;
      busy_d <= 1'b0;
      sum <= '0;
      done <= 1'b0;
    end else begin
      pair_valid <= terms.valid;
      pair_last <= terms.valid && terms.last;
      total_valid <= pair_valid;
      total_last <= pair_last;
      busy_d <= busy;
      // pulse once the last total is in the accumulator
      done <= total_last;
      if (busy && !busy_d) begin
        sum <= '0;
      end else if (total_valid) begin
        sum <= sum + sum_t'(total);
      end
    end
  end

endmodule

// File: verilog/exp_stage.sv
`timescale 1ns/1ps

module exp_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  softmax_num_pkg::lane_t max_value,
  row_if.sink                    rows,
  row_if.source                  terms
);
  import softmax_num_pkg::*;

  localparam int shift_w = $clog2(term_w);

  logic [lane_w:0] diff [lane_count];
  term_row_t       next_terms;

  always_comb begin
    for (int i = 0; i < lane_count; i++) begin
      // max is never below a lane, so the difference is nonnegative
      diff[i] = {max_value[lane_w-1], max_value} - {rows.row[i][lane_w-1], rows.row[i]};
      if (int'(diff[i]) < term_w) begin
        next_terms[i] = one_term >> diff[i][shift_w-1:0];
      end else begin
        next_terms[i] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    terms.row <= next_terms;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      terms.valid <= 1'b0;
      terms.first <= 1'b0;
      terms.last <= 1'b0;
    end else begin
      terms.valid <= rows.valid;
      terms.first <= rows.first;
      terms.last <= rows.last;
    end
  end

endmodule

// File: verilog/max_tree.sv
`timescale 1ns/1ps

module max_tree (
  input  logic                   clk,
  input  logic                   reset,
  row_if.sink                    rows,
  output softmax_num_pkg::lane_t max_value,
  output logic                   max_ready
);
  import softmax_num_pkg::*;

  lane_t pair0_max;
  lane_t pair1_max;
  lane_t row_max;

  function automatic lane_t max2(lane_t a, lane_t b);
    return (a > b) ? a : b;
  endfunction

  // two comparator levels over the four lanes
  assign pair0_max = max2(rows.row[0], rows.row[1]);
  assign pair1_max = max2(rows.row[2], rows.row[3]);
  assign row_max = max2(pair0_max, pair1_max);

  always_ff @(posedge clk) begin
    if (reset) begin
      max_value <= '0;
      max_ready <= 1'b0;
    end else begin
      max_ready <= rows.valid && rows.last;
      if (rows.valid) begin
        // first row restarts the running max
        max_value <= rows.first ? row_max : max2(max_value, row_max);
      end
    end
  end

endmodule

// File: verilog/row_buffer.sv
`timescale 1ns/1ps

module row_buffer #(
  parameter int addr_w = 3
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [addr_w-1:0]     wr_addr,
  input  logic [addr_w-1:0]     rd_addr,
  input  softmax_num_pkg::row_t wr_row,
  output softmax_num_pkg::row_t rd_row
);
  import softmax_num_pkg::*;

  // one block of rows, kept between the two passes
  row_t mem [2**addr_w];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    rd_row <= mem[rd_addr];
  end

endmodule

// File: verilog/row_if.sv
`timescale 1ns/1ps

interface row_if;
  import softmax_num_pkg::*;

  row_t row;
  logic valid;
  // pass markers
  logic first;
  logic last;

  modport source (
    output row,
    output valid,
    output first,
    output last
  );

  modport sink (
    input row,
    input valid,
    input first,
    input last
  );

endinterface

// File: verilog/softmax_seq_pkg.sv
package softmax_seq_pkg;

  // sequencer phases, one pass each for load and scan
  typedef enum logic [2:0] {
    idle,
    load,
    max_wait,
    scan,
    drain
  } phase_t;

  // buffer depth limit, matches the sum width
  localparam int max_addr_w = 8;

endpackage

// File: verilog/softmax_num_pkg.sv
package softmax_num_pkg;

  // four signed lanes per row
  localparam int lane_count = 4;
  localparam int lane_w = 16;
  typedef logic signed [lane_w-1:0] lane_t;
  typedef lane_t [lane_count-1:0] row_t;

  // base-2 terms, 2^0 sits in the top bit
  localparam int term_w = 16;
  typedef logic [term_w-1:0] term_t;
  typedef term_t [lane_count-1:0] term_row_t;
  localparam term_t one_term = term_t'(32768);

  // wide enough for 256 rows of four full terms
  typedef logic [25:0] sum_t;

endpackage
